/* hdl/benes_pipeline.sv */
module benes_pipeline import perm_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  perm_in_t  in_item,
    input  ctrl_t     slot0_ctrl,
    input  ctrl_t     slot1_ctrl,
    output perm_out_t out_item
);

    logic   ent_valid;
    lanes_t ent_data;
    ctrl_t  ent_ctrl;
    ctrl_t  sel_ctrl;

    logic   stage_v [N_STAGES+1];
    lanes_t stage_d [N_STAGES+1];
    ctrl_t  stage_c [N_STAGES+1];

    assign sel_ctrl = in_item.slot ? slot1_ctrl : slot0_ctrl;

    // entry register, the item carries its own control word from here on
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ent_valid <= 1'b0;
        end else begin
            ent_valid <= in_item.valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (in_item.valid) begin
            ent_data <= in_item.data;
            ent_ctrl <= sel_ctrl;
        end
    end

    assign stage_v[0] = ent_valid;
    assign stage_d[0] = ent_data;
    assign stage_c[0] = ent_ctrl;

    for (genvar s = 0; s < N_STAGES; s++) begin : g_stage
        perm_switch_stage #(
            .DIST (stage_dist[s])
        ) u_stage (
            .CLK       (CLK),
            .nRST      (nRST),
            .in_valid  (stage_v[s]),
            .in_data   (stage_d[s]),
            .in_ctrl   (stage_c[s]),
            .out_valid (stage_v[s+1]),
            .out_data  (stage_d[s+1]),
            .out_ctrl  (stage_c[s+1])
        );
    end

    assign out_item.valid = stage_v[N_STAGES];
    assign out_item.data  = stage_d[N_STAGES];

    // nine shifts of 16 must drain all 144 bits
    a_ctrl_drained: assert property (
        @(posedge CLK) disable iff (!nRST)
        out_item.valid |-> (stage_c[N_STAGES] == '0)
    );

endmodule

/* hdl/perm_cfg_apb.sv */
module perm_cfg_apb import perm_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  apb_req_t apb,
    output apb_rsp_t apb_rsp,
    input  logic     delivered,
    output ctrl_t    slot0_ctrl,
    output ctrl_t    slot1_ctrl
);

    perm_reg_e   reg_idx;
    logic        addr_ok;
    logic        err;
    logic        setup;
    logic        access;
    logic        wr_en;
    logic        is_slot1;
    logic [2:0]  word_idx;
    logic [31:0] rd_word;
    logic [31:0] rd_data_q;
    logic        err_q;
    logic [31:0] out_count;

    function automatic logic [31:0] get_word(ctrl_t cw, logic [2:0] w);
        logic [N_WORDS*32-1:0] wide;
        wide = '0;
        wide[CTRL_W-1:0] = cw;
        return wide[w*32 +: 32];
    endfunction

    function automatic ctrl_t put_word(ctrl_t cw, logic [2:0] w, logic [31:0] val);
        logic [N_WORDS*32-1:0] wide;
        wide = '0;
        wide[CTRL_W-1:0] = cw;
        wide[w*32 +: 32] = val;
        return wide[CTRL_W-1:0];
    endfunction

    assign setup  = apb.psel && !apb.penable;
    assign access = apb.psel && apb.penable;

    // decoded fields only mean something when addr_ok is set
    assign addr_ok  = (apb.paddr[1:0] == 2'b00) && (apb.paddr[7:2] <= 6'(OUT_COUNT));
    assign reg_idx  = perm_reg_e'(apb.paddr[5:2]);
    assign err      = !addr_ok || (apb.pwrite && reg_idx == OUT_COUNT);
    assign is_slot1 = (reg_idx >= SLOT1_W0) && (reg_idx <= SLOT1_W4);
    assign word_idx = is_slot1 ? 3'(reg_idx - SLOT1_W0) : 3'(reg_idx);
    assign wr_en    = access && apb.pwrite && !err;

    always_comb begin
        if (reg_idx == OUT_COUNT) begin
            rd_word = out_count;
        end else if (is_slot1) begin
            rd_word = get_word(slot1_ctrl, word_idx);
        end else begin
            rd_word = get_word(slot0_ctrl, word_idx);
        end
    end

    // items sampled after the access edge see the new slot word
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            slot0_ctrl <= '0;
            slot1_ctrl <= '0;
        end else if (wr_en) begin
            if (is_slot1) begin
                slot1_ctrl <= put_word(slot1_ctrl, word_idx, apb.pwdata);
            end else begin
                slot0_ctrl <= put_word(slot0_ctrl, word_idx, apb.pwdata);
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            out_count <= '0;
        end else if (delivered) begin
            out_count <= out_count + 32'd1;
        end
    end

    // captured at the end of setup and presented during access
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_data_q <= '0;
            err_q     <= 1'b0;
        end else begin
            err_q     <= setup && err;
            rd_data_q <= (setup && !apb.pwrite && !err) ? rd_word : '0;
        end
    end

    assign apb_rsp.prdata  = rd_data_q;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = err_q;

    a_penable_in_psel: assert property (
        @(posedge CLK) disable iff (!nRST)
        apb.penable |-> apb.psel
    );

    // read-back and error are decoded from the setup address
    a_paddr_stable: assert property (
        @(posedge CLK) disable iff (!nRST)
        setup |=> $stable(apb.paddr)
    );

endmodule

/* hdl/perm_pkg.sv */
package perm_pkg;

    localparam int N_LANES  = 32;
    localparam int LANE_W   = 16;
    localparam int N_STAGES = 9;
    localparam int N_SW     = 16;
    localparam int CTRL_W   = N_STAGES * N_SW;

    // 32-bit APB words per slot, last one half used
    localparam int N_WORDS  = (CTRL_W + 31) / 32;

    // exchange bit of each column, in-place butterfly form
    localparam int stage_dist [N_STAGES] = '{4, 3, 2, 1, 0, 1, 2, 3, 4};

    typedef logic [N_LANES-1:0][LANE_W-1:0] lanes_t;
    typedef logic [CTRL_W-1:0]              ctrl_t;

    typedef struct packed {
        logic   valid;
        logic   slot;
        lanes_t data;
    } perm_in_t;

    typedef struct packed {
        logic   valid;
        lanes_t data;
    } perm_out_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // word index, byte address is index * 4
    typedef enum logic [3:0] {
        SLOT0_W0  = 4'd0,
        SLOT0_W1  = 4'd1,
        SLOT0_W2  = 4'd2,
        SLOT0_W3  = 4'd3,
        SLOT0_W4  = 4'd4,
        SLOT1_W0  = 4'd5,
        SLOT1_W1  = 4'd6,
        SLOT1_W2  = 4'd7,
        SLOT1_W3  = 4'd8,
        SLOT1_W4  = 4'd9,
        OUT_COUNT = 4'd10
    } perm_reg_e;

endpackage

/* hdl/perm_switch_stage.sv */
module perm_switch_stage import perm_pkg::*; #(
    parameter int DIST = 0
) (
    input  logic   CLK,
    input  logic   nRST,
    input  logic   in_valid,
    input  lanes_t in_data,
    input  ctrl_t  in_ctrl,
    output logic   out_valid,
    output lanes_t out_data,
    output ctrl_t  out_ctrl
);

    lanes_t sw_data;

    // switch k takes the k-th pair, lower lane has bit DIST clear
    for (genvar k = 0; k < N_SW; k++) begin : g_sw
        localparam int LO = ((k >> DIST) << (DIST + 1)) | (k & ((1 << DIST) - 1));
        localparam int HI = LO + (1 << DIST);

        assign sw_data[LO] = in_ctrl[k] ? in_data[HI] : in_data[LO];
        assign sw_data[HI] = in_ctrl[k] ? in_data[LO] : in_data[HI];
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // this column's bits are used up, the rest move down
    always_ff @(posedge CLK) begin
        if (in_valid) begin
            out_data <= sw_data;
            out_ctrl <= in_ctrl >> N_SW;
        end
    end

    a_valid_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        !$isunknown(out_valid)
    );

endmodule

/* hdl/perm_unit.sv */
module perm_unit import perm_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  apb_req_t  apb,
    output apb_rsp_t  apb_rsp,
    input  perm_in_t  in_item,
    output perm_out_t out_item
);

    ctrl_t slot0_ctrl;
    ctrl_t slot1_ctrl;
    logic  delivered;

    // count every item leaving the network
    assign delivered = out_item.valid;

    perm_cfg_apb u_cfg (
        .CLK        (CLK),
        .nRST       (nRST),
        .apb        (apb),
        .apb_rsp    (apb_rsp),
        .delivered  (delivered),
        .slot0_ctrl (slot0_ctrl),
        .slot1_ctrl (slot1_ctrl)
    );

    benes_pipeline u_net (
        .CLK        (CLK),
        .nRST       (nRST),
        .in_item    (in_item),
        .slot0_ctrl (slot0_ctrl),
        .slot1_ctrl (slot1_ctrl),
        .out_item   (out_item)
    );

endmodule

/* perm_unit.f */
+incdir+sim
hdl/perm_pkg.sv
hdl/perm_switch_stage.sv
hdl/benes_pipeline.sv
hdl/perm_cfg_apb.sv
hdl/perm_unit.sv
sim/perm_unit_tb.sv

/* sim/perm_model.svh */
`ifndef PERM_MODEL_SVH
`define PERM_MODEL_SVH

// reference permutation, applied column by column
function automatic lanes_t apply_perm(lanes_t din, ctrl_t cw);
    int     dists [9] = '{4, 3, 2, 1, 0, 1, 2, 3, 4};
    lanes_t cur;
    lanes_t nxt;
    int     step;
    int     k;
    cur = din;
    for (int s = 0; s < 9; s++) begin
        step = 1 << dists[s];
        k = 0;
        nxt = cur;
        // pairs counted by ascending lower lane
        for (int lo = 0; lo < 32; lo++) begin
            if ((lo & step) == 0) begin
                if (cw[16*s + k]) begin
                    nxt[lo]        = cur[lo + step];
                    nxt[lo + step] = cur[lo];
                end
                k++;
            end
        end
        cur = nxt;
    end
    return cur;
endfunction

// APB word w of a control word, zero above bit 143
function automatic logic [31:0] ctrl_word(ctrl_t cw, int w);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < 32; b++) begin
        if (32*w + b < CTRL_W) begin
            v[b] = cw[32*w + b];
        end
    end
    return v;
endfunction

function automatic ctrl_t set_ctrl_word(ctrl_t cw, int w, logic [31:0] v);
    ctrl_t r;
    r = cw;
    for (int b = 0; b < 32; b++) begin
        if (32*w + b < CTRL_W) begin
            r[32*w + b] = v[b];
        end
    end
    return r;
endfunction

`endif

/* sim/perm_unit_tb.sv */
module perm_unit_tb import perm_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ITEMS_TOTAL = 4 + N_STAGES * 2 + 40 + 24;
    localparam int APB_TOTAL   = N_STAGES * 5 + 10 + 5 + 12 + 9;
    localparam int DRAINS      = 3 + N_STAGES;
    localparam int WATCHDOG_NS =
        (ITEMS_TOTAL + 2 * APB_TOTAL + DRAINS * (N_STAGES + 3) + 20) * 20 + 1000;

    logic        CLK;
    logic        nRST;
    apb_req_t    apb;
    apb_rsp_t    apb_rsp;
    perm_in_t    in_item;
    perm_out_t   out_item;
    lanes_t      exp_q [$];
    lanes_t      exp_head = '0;
    int          exp_cnt = 0;
    ctrl_t       slot_cw [2] = '{'0, '0};
    logic        exp_err = 1'b0;
    logic        chk_rd = 1'b0;
    logic [31:0] exp_rd = '0;
    string       test_name = "reset";
    int          n_err = 0;
    int          err_at_start;
    int          n_pass = 0;
    int          n_fail = 0;
    int          n_sent = 0;

    `include "perm_model.svh"

    perm_unit dut0 (
        .CLK      (CLK),
        .nRST     (nRST),
        .apb      (apb),
        .apb_rsp  (apb_rsp),
        .in_item  (in_item),
        .out_item (out_item)
    );

    initial CLK = 1'b0;
    always #10 CLK = ~CLK;

    function automatic void update_head();
        exp_cnt  = exp_q.size();
        exp_head = (exp_cnt > 0) ? exp_q[0] : '0;
    endfunction

    // the DUT's slot contents as the testbench wrote them
    function automatic void note_write(logic [7:0] addr, logic [31:0] data);
        int idx;
        idx = addr >> 2;
        if (idx < 5) begin
            slot_cw[0] = set_ctrl_word(slot_cw[0], idx, data);
        end else if (idx < 10) begin
            slot_cw[1] = set_ctrl_word(slot_cw[1], idx - 5, data);
        end
    endfunction

    function automatic lanes_t rand_lanes();
        lanes_t v;
        for (int i = 0; i < N_LANES; i++) begin
            v[i] = LANE_W'($urandom);
        end
        return v;
    endfunction

    function automatic ctrl_t rand_ctrl();
        ctrl_t v;
        v = '0;
        for (int w = 0; w < 5; w++) begin
            v = set_ctrl_word(v, w, $urandom);
        end
        return v;
    endfunction

    task automatic apb_access(logic wr, logic [7:0] addr, logic [31:0] data,
                              logic [31:0] rdata, logic err);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = wr;
        apb.paddr   = addr;
        apb.pwdata  = data;
        @(posedge CLK);
        #2;
        apb.penable = 1'b1;
        exp_err     = err;
        chk_rd      = !wr;
        exp_rd      = err ? 32'd0 : rdata;
        @(posedge CLK);
        // takes effect at this edge before the next item is computed
        if (wr && !err) begin
            note_write(addr, data);
        end
        #2;
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
        chk_rd      = 1'b0;
    endtask

    task automatic write_slot(int slot, ctrl_t cw);
        for (int w = 0; w < 5; w++) begin
            apb_access(1'b1, 8'((slot * 5 + w) * 4), ctrl_word(cw, w), '0, 1'b0);
        end
    endtask

    // mode 0 or 1 picks that slot and 2 picks at random
    task automatic send_random(int n, int mode);
        logic slot;
        lanes_t data;
        for (int i = 0; i < n; i++) begin
            slot = (mode == 2) ? 1'($urandom) : mode[0];
            data = rand_lanes();
            in_item = '{valid: 1'b1, slot: slot, data: data};
            exp_q.push_back(apply_perm(data, slot_cw[slot]));
            update_head();
            n_sent++;
            @(posedge CLK);
            #2;
        end
        in_item.valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_cnt != 0) begin
            @(posedge CLK);
        end
        @(posedge CLK);
        #2;
    endtask

    task automatic start_test(string name);
        test_name    = name;
        err_at_start = n_err;
    endtask

    task automatic end_test();
        if (n_err == err_at_start) begin
            $display("test %s: passed", test_name);
            n_pass++;
        end else begin
            $display("test %s: %0d errors", test_name, n_err - err_at_start);
            n_fail++;
        end
    endtask

    always @(posedge CLK) begin
        if (nRST && out_item.valid && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            update_head();
        end
    end

    // out valid rises right after the ninth edge past the sampling edge
    a_out_latency: assert property (@(posedge CLK) disable iff (!nRST)
        in_item.valid |-> ##10 out_item.valid)
        else begin
            n_err++;
            $display("in test %s an item did not come out nine cycles after entry",
                     test_name);
        end

    a_out_expected: assert property (@(posedge CLK) disable iff (!nRST)
        out_item.valid |-> exp_cnt > 0)
        else begin
            n_err++;
            $display("in test %s an item came out that was never sent", test_name);
        end

    a_out_match: assert property (@(posedge CLK) disable iff (!nRST)
        (out_item.valid && exp_cnt > 0) |-> out_item.data == exp_head)
        else begin
            n_err++;
            $display("FAIL %s expected %h actual %h", test_name,
                     $sampled(exp_head), $sampled(out_item.data));
        end

    a_apb_ready: assert property (@(posedge CLK) disable iff (!nRST)
        (apb.psel && apb.penable) |-> apb_rsp.pready)
        else begin
            n_err++;
            $display("in test %s pready was low in an access cycle", test_name);
        end

    a_apb_err: assert property (@(posedge CLK) disable iff (!nRST)
        (apb.psel && apb.penable) |-> apb_rsp.pslverr == exp_err)
        else begin
            n_err++;
            $display("FAIL %s expected pslverr %b actual %b", test_name,
                     $sampled(exp_err), $sampled(apb_rsp.pslverr));
        end

    a_apb_rdata: assert property (@(posedge CLK) disable iff (!nRST)
        (apb.psel && apb.penable && chk_rd) |-> apb_rsp.prdata == exp_rd)
        else begin
            n_err++;
            $display("FAIL %s expected prdata %h actual %h", test_name,
                     $sampled(exp_rd), $sampled(apb_rsp.prdata));
        end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, tests still running after %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    initial begin
        ctrl_t cw;
        nRST    = 1'b0;
        apb     = '0;
        in_item = '0;
        void'($urandom(32'hfc95));
        repeat (2) @(posedge CLK);
        #2;
        nRST = 1'b1;
        @(posedge CLK);
        #2;

        start_test("identity");
        send_random(2, 0);
        send_random(2, 1);
        drain();
        end_test();

        start_test("single_stage");
        for (int s = 0; s < N_STAGES; s++) begin
            cw = '0;
            cw[16*s +: 16] = 16'hffff;
            write_slot(0, cw);
            send_random(2, 0);
            drain();
        end
        end_test();

        start_test("random_stream");
        write_slot(0, rand_ctrl());
        write_slot(1, rand_ctrl());
        send_random(40, 2);
        drain();
        end_test();

        // slot 0 rewritten word by word while items stream through it
        start_test("reconfig");
        cw = rand_ctrl();
        fork
            send_random(24, 0);
            begin
                repeat (6) @(posedge CLK);
                #2;
                write_slot(0, cw);
            end
        join
        drain();
        end_test();

        start_test("readback");
        // word 4 keeps only bits 143 to 128
        apb_access(1'b1, 8'd16, 32'ha5a5_5a5a, '0, 1'b0);
        for (int w = 0; w < 10; w++) begin
            apb_access(1'b0, 8'(w * 4), '0, ctrl_word(slot_cw[w / 5], w % 5), 1'b0);
        end
        apb_access(1'b0, 8'd40, '0, 32'(n_sent), 1'b0);
        end_test();

        start_test("apb_errors");
        apb_access(1'b1, 8'd40, 32'hdead_beef, '0, 1'b1);
        apb_access(1'b0, 8'd40, '0, 32'(n_sent), 1'b0);
        apb_access(1'b1, 8'd44, 32'h1234_5678, '0, 1'b1);
        apb_access(1'b0, 8'd12, '0, ctrl_word(slot_cw[0], 3), 1'b0);
        apb_access(1'b0, 8'd44, '0, '0, 1'b1);
        apb_access(1'b0, 8'hfc, '0, '0, 1'b1);
        apb_access(1'b1, 8'd1, 32'hffff_ffff, '0, 1'b1);
        apb_access(1'b0, 8'd0, '0, ctrl_word(slot_cw[0], 0), 1'b0);
        apb_access(1'b0, 8'd6, '0, '0, 1'b1);
        end_test();

        $display("tests passed %0d, failed %0d, check errors %0d", n_pass, n_fail, n_err);
        if (n_fail == 0 && n_err == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
